//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module core_tb -f tb.f -o Vcore_tb
	./obj_dir/Vcore_tb | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- rtl/core_dbg.sv
`timescale 1ns/1ps
// Halted is reported only once fetch, decode and execute are all empty.
module core_dbg (
    input  logic clk,
    input  logic rst_i,
    input  logic halt_req_i,
    input  logic if_valid_i,
    input  logic id_valid_i,
    input  logic ex_valid_i,
    output logic halt_core_o,
    output logic halted_o
);

    typedef enum logic [1:0] {
        ST_RUN,
        ST_DRAIN,
        ST_HALTED
    } dbg_state_e;

    dbg_state_e state_q;
    dbg_state_e state_d;
    logic       pipe_empty;

    assign pipe_empty = !(if_valid_i || id_valid_i || ex_valid_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RUN:    if (halt_req_i) state_d = ST_DRAIN;
            ST_DRAIN: begin
                if (!halt_req_i) begin
                    state_d = ST_RUN;
                end else if (pipe_empty) begin
                    state_d = ST_HALTED;
                end
            end
            ST_HALTED: if (!halt_req_i) state_d = ST_RUN;
            default:   state_d = ST_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // Fetch stops as soon as a halt is pending
    assign halt_core_o = (state_q != ST_RUN);
    assign halted_o    = (state_q == ST_HALTED);

endmodule

//--- rtl/core_pkg.sv
// Shared types for the RV32I subset core. Addresses are byte addresses, and all
// memory accesses are full 32-bit words.
package core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] instr_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // --------------------------------------------------------------------------
    // Stage payloads
    // --------------------------------------------------------------------------
    typedef struct packed {
        instr_t instr;
        xlen_t  pc;
    } if_id_t;

    typedef struct packed {
        xlen_t     pc;
        xlen_t     rs1_val;
        xlen_t     rs2_val;
        xlen_t     imm;
        reg_addr_t rd;
        alu_op_e   alu_op;
        logic      use_imm;
        logic      is_load;
        logic      is_store;
        logic      is_beq;
        logic      is_bne;
        logic      is_jal;
        logic      writes_rd;
    } id_ex_t;

    typedef struct packed {
        xlen_t     result;
        xlen_t     store_data;
        reg_addr_t rd;
        logic      is_load;
        logic      is_store;
        logic      writes_rd;
    } ex_mem_t;

endpackage

//--- rtl/core_top.sv
`timescale 1ns/1ps
// Both memories are read combinationally in the cycle of the request.
// Debug register reads are meant for use while dbg_halted_o is high.
module core_top import core_pkg::*; #(
    parameter xlen_t RESET_PC = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      rst_i,
    output xlen_t     imem_addr_o,
    input  instr_t    imem_data_i,
    output logic      dmem_req_o,
    output logic      dmem_we_o,
    output xlen_t     dmem_addr_o,
    output xlen_t     dmem_wdata_o,
    input  xlen_t     dmem_rdata_i,
    input  logic      dbg_halt_i,
    output logic      dbg_halted_o,
    input  reg_addr_t dbg_reg_addr_i,
    output xlen_t     dbg_reg_data_o
);

    // IF to ID
    logic      if_id_valid;
    logic      id_if_ack;
    if_id_t    if_id;

    // ID to EX
    logic      id_ex_valid;
    logic      ex_id_ack;
    id_ex_t    id_ex;

    // EX to MEM/WB, ack is unused since MEM/WB never stalls
    logic      ex_mem_valid;
    ex_mem_t   ex_mem;

    // Redirect
    logic      branch;
    xlen_t     branch_target;

    // Register file
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    logic      wb_en;
    reg_addr_t wb_rd;
    xlen_t     wb_data;

    logic      halt_core;

    // --------------------------------------------------------------------------
    // Pipeline stages
    // --------------------------------------------------------------------------
    if_stage #(
        .RESET_PC    ( RESET_PC      )
    ) if_stage_i (
        .clk         ( clk           ),
        .rst_i       ( rst_i         ),
        .halt_i      ( halt_core     ),
        .branch_i    ( branch        ),
        .target_i    ( branch_target ),
        .ack_i       ( id_if_ack     ),
        .valid_o     ( if_id_valid   ),
        .out_o       ( if_id         ),
        .imem_addr_o ( imem_addr_o   ),
        .imem_data_i ( imem_data_i   )
    );

    id_stage id_stage_i (
        .clk        ( clk         ),
        .rst_i      ( rst_i       ),
        .flush_i    ( branch      ),
        .valid_i    ( if_id_valid ),
        .in_i       ( if_id       ),
        .ack_o      ( id_if_ack   ),
        .rs1_addr_o ( rs1_addr    ),
        .rs2_addr_o ( rs2_addr    ),
        .rs1_data_i ( rs1_data    ),
        .rs2_data_i ( rs2_data    ),
        .wb_en_i    ( wb_en       ),
        .wb_rd_i    ( wb_rd       ),
        .ack_i      ( ex_id_ack   ),
        .valid_o    ( id_ex_valid ),
        .out_o      ( id_ex       )
    );

    ex_stage ex_stage_i (
        .clk      ( clk           ),
        .rst_i    ( rst_i         ),
        .valid_i  ( id_ex_valid   ),
        .in_i     ( id_ex         ),
        .ack_o    ( ex_id_ack     ),
        .valid_o  ( ex_mem_valid  ),
        .out_o    ( ex_mem        ),
        .branch_o ( branch        ),
        .target_o ( branch_target )
    );

    mem_wb_stage mem_wb_stage_i (
        .clk          ( clk          ),
        .rst_i        ( rst_i        ),
        .valid_i      ( ex_mem_valid ),
        .in_i         ( ex_mem       ),
        .ack_o        (              ),
        .dmem_req_o   ( dmem_req_o   ),
        .dmem_we_o    ( dmem_we_o    ),
        .dmem_addr_o  ( dmem_addr_o  ),
        .dmem_wdata_o ( dmem_wdata_o ),
        .dmem_rdata_i ( dmem_rdata_i ),
        .wb_en_o      ( wb_en        ),
        .wb_rd_o      ( wb_rd        ),
        .wb_data_o    ( wb_data      )
    );

    // --------------------------------------------------------------------------
    // Register file and debug
    // --------------------------------------------------------------------------
    register_file register_file_i (
        .clk        ( clk            ),
        .rst_i      ( rst_i          ),
        .rs1_addr_i ( rs1_addr       ),
        .rs2_addr_i ( rs2_addr       ),
        .rs1_data_o ( rs1_data       ),
        .rs2_data_o ( rs2_data       ),
        .wr_en_i    ( wb_en          ),
        .rd_i       ( wb_rd          ),
        .wr_data_i  ( wb_data        ),
        .dbg_addr_i ( dbg_reg_addr_i ),
        .dbg_data_o ( dbg_reg_data_o )
    );

    core_dbg core_dbg_i (
        .clk         ( clk          ),
        .rst_i       ( rst_i        ),
        .halt_req_i  ( dbg_halt_i   ),
        .if_valid_i  ( if_id_valid  ),
        .id_valid_i  ( id_ex_valid  ),
        .ex_valid_i  ( ex_mem_valid ),
        .halt_core_o ( halt_core    ),
        .halted_o    ( dbg_halted_o )
    );

endmodule

//--- rtl/ex_stage.sv
`timescale 1ns/1ps
// Branches resolve here. A taken branch or JAL redirects fetch while it sits in
// the output slot, and nothing is accepted from decode in that cycle.
module ex_stage import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_i,
    input  logic    valid_i,
    input  id_ex_t  in_i,
    output logic    ack_o,
    output logic    valid_o,
    output ex_mem_t out_o,
    output logic    branch_o,
    output xlen_t   target_o
);

    xlen_t   op_b;
    xlen_t   alu_res;
    logic    operands_eq;
    logic    taken;
    logic    accept;
    logic    valid_q;
    logic    taken_q;
    xlen_t   target_q;
    ex_mem_t out_q;

    assign op_b = in_i.use_imm ? in_i.imm : in_i.rs2_val;

    always_comb begin
        case (in_i.alu_op)
            ALU_ADD: alu_res = in_i.rs1_val + op_b;
            ALU_SUB: alu_res = in_i.rs1_val - op_b;
            ALU_AND: alu_res = in_i.rs1_val & op_b;
            ALU_OR:  alu_res = in_i.rs1_val | op_b;
            ALU_XOR: alu_res = in_i.rs1_val ^ op_b;
            ALU_SLT: alu_res = {31'b0, $signed(in_i.rs1_val) < $signed(op_b)};
            default: alu_res = op_b;
        endcase
    end

    // Branch decision always compares the two register operands
    assign operands_eq = (in_i.rs1_val == in_i.rs2_val);
    assign taken = in_i.is_jal || (in_i.is_beq && operands_eq)
                || (in_i.is_bne && !operands_eq);

    // Memory stage never stalls, so the only hold is our own redirect
    assign ack_o  = !branch_o;
    assign accept = valid_i && ack_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_q.result     <= in_i.is_jal ? in_i.pc + 32'd4 : alu_res;
            out_q.store_data <= in_i.rs2_val;
            out_q.rd         <= in_i.rd;
            out_q.is_load    <= in_i.is_load;
            out_q.is_store   <= in_i.is_store;
            out_q.writes_rd  <= in_i.writes_rd;
            taken_q          <= taken;
            target_q         <= in_i.pc + in_i.imm;
        end
    end

    assign valid_o  = valid_q;
    assign out_o    = out_q;
    assign branch_o = valid_q && taken_q;
    assign target_o = target_q;

endmodule

//--- rtl/id_stage.sv
`timescale 1ns/1ps
// Unsupported encodings pass on as no-ops. Loads and stores are treated as LW and SW.
// Read-after-write and write-after-write hazards stall here; there is no forwarding.
module id_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      flush_i,
    input  logic      valid_i,
    input  if_id_t    in_i,
    output logic      ack_o,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    input  xlen_t     rs1_data_i,
    input  xlen_t     rs2_data_i,
    input  logic      wb_en_i,
    input  reg_addr_t wb_rd_i,
    input  logic      ack_i,
    output logic      valid_o,
    output id_ex_t    out_o
);

    instr_t      instr;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic        uses_rs1;
    logic        uses_rs2;
    logic        hazard;
    logic [31:0] clr_mask;
    logic [31:0] slot_mask;
    logic [31:0] busy;
    logic [31:0] pending_q;
    logic        valid_q;
    id_ex_t      dec;
    id_ex_t      out_q;

    assign instr      = in_i.instr;
    assign opcode     = instr[6:0];
    assign funct3     = instr[14:12];
    assign rd         = instr[11:7];
    assign rs1_addr_o = instr[19:15];
    assign rs2_addr_o = instr[24:20];

    // --------------------------------------------------------------------------
    // Decode and immediate generation
    // --------------------------------------------------------------------------
    always_comb begin
        dec         = '0;
        dec.pc      = in_i.pc;
        dec.rs1_val = rs1_data_i;
        dec.rs2_val = rs2_data_i;
        dec.rd      = rd;
        dec.alu_op  = ALU_ADD;
        uses_rs1    = 1'b0;
        uses_rs2    = 1'b0;
        case (opcode)
            OPC_OP: begin
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                dec.writes_rd = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = instr[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: dec.writes_rd = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // ADDI only
                uses_rs1      = 1'b1;
                dec.use_imm   = 1'b1;
                dec.imm       = {{20{instr[31]}}, instr[31:20]};
                dec.writes_rd = (funct3 == 3'b000);
            end
            OPC_LUI: begin
                dec.alu_op    = ALU_PASS_B;
                dec.use_imm   = 1'b1;
                dec.imm       = {instr[31:12], 12'b0};
                dec.writes_rd = 1'b1;
            end
            OPC_LOAD: begin
                uses_rs1      = 1'b1;
                dec.use_imm   = 1'b1;
                dec.imm       = {{20{instr[31]}}, instr[31:20]};
                dec.is_load   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OPC_STORE: begin
                uses_rs1     = 1'b1;
                uses_rs2     = 1'b1;
                dec.use_imm  = 1'b1;
                dec.imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                dec.is_store = 1'b1;
            end
            OPC_BRANCH: begin
                uses_rs1   = 1'b1;
                uses_rs2   = 1'b1;
                dec.imm    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
                dec.is_beq = (funct3 == 3'b000);
                dec.is_bne = (funct3 == 3'b001);
            end
            OPC_JAL: begin
                dec.imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                 instr[30:21], 1'b0};
                dec.is_jal    = 1'b1;
                dec.writes_rd = 1'b1;
            end
            default: ;
        endcase
        // x0 is never tracked or written
        dec.writes_rd = dec.writes_rd && (rd != 5'd0);
    end

    // --------------------------------------------------------------------------
    // Scoreboard
    // --------------------------------------------------------------------------
    // Marks are set on issue to EX; the slot's own rd counts as busy until then
    always_comb begin
        clr_mask  = '0;
        slot_mask = '0;
        if (wb_en_i) begin
            clr_mask[wb_rd_i] = 1'b1;
        end
        if (valid_q && out_q.writes_rd) begin
            slot_mask[out_q.rd] = 1'b1;
        end
    end

    // Register being written back is readable through the register file bypass
    assign busy   = (pending_q & ~clr_mask) | slot_mask;
    assign hazard = (uses_rs1 && busy[rs1_addr_o]) || (uses_rs2 && busy[rs2_addr_o])
                 || (dec.writes_rd && busy[rd]);
    assign ack_o  = valid_i && !flush_i && !hazard && (!valid_q || ack_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q   <= 1'b0;
            pending_q <= '0;
        end else begin
            if (flush_i) begin
                valid_q <= 1'b0;
            end else if (ack_o) begin
                valid_q <= 1'b1;
            end else if (ack_i) begin
                valid_q <= 1'b0;
            end
            pending_q <= (pending_q & ~clr_mask) | (ack_i ? slot_mask : '0);
        end
    end

    always_ff @(posedge clk) begin
        if (ack_o) begin
            out_q <= dec;
        end
    end

    assign valid_o = valid_q;
    assign out_o   = out_q;

endmodule

//--- rtl/if_stage.sv
`timescale 1ns/1ps
// Instruction memory must answer in the same cycle. RESET_PC must be word aligned.
module if_stage import core_pkg::*; #(
    parameter xlen_t RESET_PC = 32'h0000_0000
) (
    input  logic   clk,
    input  logic   rst_i,
    input  logic   halt_i,
    input  logic   branch_i,
    input  xlen_t  target_i,
    input  logic   ack_i,
    output logic   valid_o,
    output if_id_t out_o,
    output xlen_t  imem_addr_o,
    input  instr_t imem_data_i
);

    xlen_t  pc_q;
    logic   valid_q;
    if_id_t out_q;
    logic   fill;

    assign imem_addr_o = pc_q;

    // Slot takes a new word when empty or handed on this cycle
    assign fill = !halt_i && (!valid_q || ack_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q    <= RESET_PC;
            valid_q <= 1'b0;
        end else if (branch_i) begin
            // Wrong-path word is dropped, fetch resumes at the target
            pc_q    <= target_i;
            valid_q <= 1'b0;
        end else if (fill) begin
            pc_q    <= pc_q + 32'd4;
            valid_q <= 1'b1;
        end else if (ack_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            out_q.instr <= imem_data_i;
            out_q.pc    <= pc_q;
        end
    end

    assign valid_o = valid_q;
    assign out_o   = out_q;

endmodule

//--- rtl/mem_wb_stage.sv
`timescale 1ns/1ps
// Data memory must answer in the same cycle. Only full-word accesses are issued.
module mem_wb_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      valid_i,
    input  ex_mem_t   in_i,
    output logic      ack_o,
    output logic      dmem_req_o,
    output logic      dmem_we_o,
    output xlen_t     dmem_addr_o,
    output xlen_t     dmem_wdata_o,
    input  xlen_t     dmem_rdata_i,
    output logic      wb_en_o,
    output reg_addr_t wb_rd_o,
    output xlen_t     wb_data_o
);

    logic      accept;
    logic      wb_en_q;
    reg_addr_t wb_rd_q;
    xlen_t     wb_data_q;

    // Never stalls
    assign ack_o  = 1'b1;
    assign accept = valid_i && ack_o;

    // Access goes out in the cycle the instruction arrives
    assign dmem_req_o   = accept && (in_i.is_load || in_i.is_store);
    assign dmem_we_o    = accept && in_i.is_store;
    assign dmem_addr_o  = in_i.result;
    assign dmem_wdata_o = in_i.store_data;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_en_q <= 1'b0;
        end else begin
            wb_en_q <= accept && in_i.writes_rd && (in_i.rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb_rd_q   <= in_i.rd;
            wb_data_q <= in_i.is_load ? dmem_rdata_i : in_i.result;
        end
    end

    assign wb_en_o   = wb_en_q;
    assign wb_rd_o   = wb_rd_q;
    assign wb_data_o = wb_data_q;

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps
// Core reads see a same-cycle write. The debug read returns one cycle after its address.
module register_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    input  logic      wr_en_i,
    input  reg_addr_t rd_i,
    input  xlen_t     wr_data_i,
    input  reg_addr_t dbg_addr_i,
    output xlen_t     dbg_data_o
);

    xlen_t regs_q [31:1];
    xlen_t dbg_data_q;

    function automatic xlen_t read_port(input reg_addr_t addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (wr_en_i && (rd_i == addr)) begin
            return wr_data_i;
        end
        return regs_q[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (rd_i != 5'd0)) begin
            regs_q[rd_i] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        dbg_data_q <= read_port(dbg_addr_i);
    end

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);
    assign dbg_data_o = dbg_data_q;

endmodule

//--- tb.f
+incdir+verif
rtl/core_pkg.sv
rtl/if_stage.sv
rtl/id_stage.sv
rtl/ex_stage.sv
rtl/mem_wb_stage.sv
rtl/register_file.sv
rtl/core_dbg.sv
rtl/core_top.sv
verif/core_tb.sv

//--- verif/core_ref_model.svh
// Instruction-set model of the RV32I subset. Loads and stores are whole words,
// and the run stops at the self-loop JAL x0,0 or after MODEL_LIMIT steps.
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

localparam int     MODEL_LIMIT = 5000;
localparam instr_t SELF_LOOP   = 32'h0000_006f;

xlen_t exp_regs [32];
xlen_t exp_dmem [1024];

// Runs the program in imem from address 0, returns the number of retired steps
function automatic int run_model();
    xlen_t      pc;
    instr_t     ins;
    int         steps;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [4:0] rd;
    xlen_t      a;
    xlen_t      b;
    xlen_t      res;
    xlen_t      next_pc;
    logic       wr;
    pc    = '0;
    steps = 0;
    for (int i = 0; i < 32; i++) begin
        exp_regs[i] = '0;
    end
    while (steps < MODEL_LIMIT) begin
        ins = imem[pc[11:2]];
        if (ins == SELF_LOOP) begin
            break;
        end
        opc     = ins[6:0];
        f3      = ins[14:12];
        rd      = ins[11:7];
        a       = exp_regs[ins[19:15]];
        b       = exp_regs[ins[24:20]];
        next_pc = pc + 32'd4;
        wr      = 1'b0;
        res     = '0;
        if (opc == OPC_OP) begin
            wr = 1'b1;
            case (f3)
                3'b000:  res = ins[30] ? a - b : a + b;
                3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b100:  res = a ^ b;
                3'b110:  res = a | b;
                3'b111:  res = a & b;
                default: wr = 1'b0;
            endcase
        end else if (opc == OPC_OP_IMM && f3 == 3'b000) begin
            wr  = 1'b1;
            res = a + {{20{ins[31]}}, ins[31:20]};
        end else if (opc == OPC_LUI) begin
            wr  = 1'b1;
            res = {ins[31:12], 12'b0};
        end else if (opc == OPC_LOAD) begin
            res = a + {{20{ins[31]}}, ins[31:20]};
            res = exp_dmem[res[11:2]];
            wr  = 1'b1;
        end else if (opc == OPC_STORE) begin
            res = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            exp_dmem[res[11:2]] = b;
        end else if (opc == OPC_BRANCH) begin
            if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
        end else if (opc == OPC_JAL) begin
            wr      = 1'b1;
            res     = pc + 32'd4;
            next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        if (wr && rd != 5'd0) begin
            exp_regs[rd] = res;
        end
        pc    = next_pc;
        steps = steps + 1;
    end
    return steps;
endfunction

`endif

//--- verif/core_tb.sv
`timescale 1ns/1ps
// Runs directed and random programs on core_top and checks registers and data
// memory against the model after a debug halt. Memories are 1024 words each.
module core_tb import core_pkg::*;;

    localparam int SEED = 32'hce87b26a;

    logic      clk = 1'b0;
    logic      rst_i;
    xlen_t     imem_addr;
    instr_t    imem_data;
    logic      dmem_req;
    logic      dmem_we;
    xlen_t     dmem_addr;
    xlen_t     dmem_wdata;
    xlen_t     dmem_rdata;
    logic      dbg_halt;
    logic      dbg_halted;
    reg_addr_t dbg_addr;
    xlen_t     dbg_data;

    instr_t imem [1024];
    xlen_t  dmem [1024];
    instr_t prog [$];
    string  test_name;
    int     errors = 0;
    int     budget = 2000;
    int     cycles = 0;

    `include "core_ref_model.svh"

    core_top #(.RESET_PC(32'h0000_0000)) core_top_i (
        .clk            ( clk        ),
        .rst_i          ( rst_i      ),
        .imem_addr_o    ( imem_addr  ),
        .imem_data_i    ( imem_data  ),
        .dmem_req_o     ( dmem_req   ),
        .dmem_we_o      ( dmem_we    ),
        .dmem_addr_o    ( dmem_addr  ),
        .dmem_wdata_o   ( dmem_wdata ),
        .dmem_rdata_i   ( dmem_rdata ),
        .dbg_halt_i     ( dbg_halt   ),
        .dbg_halted_o   ( dbg_halted ),
        .dbg_reg_addr_i ( dbg_addr   ),
        .dbg_reg_data_o ( dbg_data   )
    );

    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // Memory models
    // ------------------------------------------------------------------------
    function automatic xlen_t fill_word(input int idx);
        return (idx * 32'h9e37_79b9) ^ 32'h00c0_ffee;
    endfunction

    assign imem_data  = imem[imem_addr[11:2]];
    assign dmem_rdata = dmem[dmem_addr[11:2]];

    // Data memory goes back to its fill pattern while reset is high
    always @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 1024; i++) begin
                dmem[i] <= fill_word(i);
            end
        end else if (dmem_req && dmem_we) begin
            dmem[dmem_addr[11:2]] <= dmem_wdata;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > budget) begin
            $display("Watchdog expired after %0d cycles in %s", cycles, test_name);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Instruction encoders
    // ------------------------------------------------------------------------
    function automatic instr_t enc_r(input int f7, input int rs2, input int rs1,
                                     input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic instr_t enc_i(input int imm, input int rs1, input int f3,
                                     input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic instr_t enc_s(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_t enc_b(input int imm, input int rs2, input int rs1, input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                OPC_BRANCH};
    endfunction

    function automatic instr_t enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic instr_t enc_lui(input int imm20, input int rd);
        return {imm20[19:0], rd[4:0], OPC_LUI};
    endfunction

    function automatic instr_t addi(input int rd, input int rs1, input int imm);
        return enc_i(imm, rs1, 0, rd, OPC_OP_IMM);
    endfunction

    // ------------------------------------------------------------------------
    // Run and compare
    // ------------------------------------------------------------------------
    task automatic run_program(input string name);
        int steps;
        int wait_cycles;
        xlen_t got;
        test_name = name;
        // Halt request held through reset, halted status must stay low
        dbg_halt  = 1'b1;
        rst_i     = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
            assert (!dbg_halted && !dmem_req) else begin
                errors++;
                $display("Halted or dmem request seen during reset in %s", name);
            end
        end
        for (int i = 0; i < 1024; i++) begin
            imem[i]     = (i < prog.size()) ? prog[i] : SELF_LOOP;
            exp_dmem[i] = fill_word(i);
        end
        steps = run_model();
        wait_cycles = (steps + 1) * 20;
        budget = budget + wait_cycles + 400;
        dbg_halt = 1'b0;
        rst_i = 1'b0;
        repeat (wait_cycles) @(posedge clk);
        #1;
        dbg_halt = 1'b1;
        for (int n = 0; n < 100 && !dbg_halted; n++) begin
            @(posedge clk);
            #1;
        end
        assert (dbg_halted) else begin
            errors++;
            $display("Core never reported halted in %s", name);
        end
        for (int r = 0; r < 32; r++) begin
            dbg_addr = r[4:0];
            @(posedge clk);
            #1;
            got = dbg_data;
            assert (got == exp_regs[r]) else begin
                errors++;
                $display("Fail %s x%0d expected %h actual %h", name, r, exp_regs[r], got);
            end
        end
        for (int i = 0; i < 1024; i++) begin
            assert (dmem[i] == exp_dmem[i]) else begin
                errors++;
                $display("Fail %s dmem[%0d] expected %h actual %h", name, i, exp_dmem[i],
                         dmem[i]);
            end
        end
        dbg_halt = 1'b0;
        @(posedge clk);
        #1;
        assert (!dbg_halted) else begin
            errors++;
            $display("Halted status stayed high after halt release in %s", name);
        end
        prog.delete();
    endtask

    initial begin
        int unused_seed;
        int kind;
        int funct3;
        rst_i    = 1'b1;
        dbg_halt = 1'b0;
        dbg_addr = '0;
        unused_seed = $urandom(SEED);

        // ALU and immediates, SUB underflow, signed SLT, LUI, writes to x0
        prog = '{addi(1, 0, 5), addi(2, 0, -7), enc_r(32, 2, 1, 0, 3), enc_r(32, 1, 0, 0, 4),
                 enc_r(0, 1, 2, 2, 5), enc_r(0, 2, 1, 2, 6), enc_r(0, 2, 1, 7, 7),
                 enc_r(0, 2, 1, 6, 8), enc_r(0, 2, 1, 4, 9), enc_lui(20'habcde, 10),
                 addi(11, 10, -1), addi(0, 1, 3), enc_r(0, 1, 1, 0, 0), SELF_LOOP};
        run_program("alu");

        // Each instruction uses the previous rd
        prog.push_back(addi(1, 0, 1));
        for (int i = 2; i < 16; i++) begin
            prog.push_back(enc_r(0, i - 1, i - 1, 0, i));
        end
        prog.push_back(enc_r(32, 1, 15, 0, 16));
        prog.push_back(enc_r(0, 16, 15, 4, 17));
        prog.push_back(SELF_LOOP);
        run_program("chain");

        // Mixed SW and LW, load right after store to the same address
        prog = '{addi(1, 0, 64), addi(2, 0, 123), enc_s(0, 2, 1), enc_i(0, 1, 2, 3, OPC_LOAD),
                 enc_s(4, 3, 1), enc_i(4, 1, 2, 4, OPC_LOAD), enc_lui(20'h12345, 5),
                 enc_s(8, 5, 1), enc_i(8, 1, 2, 6, OPC_LOAD), enc_i(12, 1, 2, 7, OPC_LOAD),
                 enc_r(0, 7, 6, 0, 8), enc_s(-4, 8, 1), enc_i(-4, 1, 2, 9, OPC_LOAD), SELF_LOOP};
        run_program("load_store");

        // Wrong-path words after each taken branch write x10 and up
        prog = '{addi(1, 0, 3), addi(2, 0, 3), enc_b(12, 2, 1, 0), addi(10, 0, 99),
                 addi(11, 0, 99), addi(3, 0, 1), enc_b(8, 2, 1, 1), addi(4, 0, 2),
                 enc_b(12, 0, 1, 1), addi(12, 0, 99), addi(13, 0, 99), enc_b(8, 0, 1, 0),
                 addi(5, 0, 5), enc_j(12, 6), addi(14, 0, 99), addi(15, 0, 99),
                 addi(7, 6, 0), SELF_LOOP};
        run_program("branch");

        // Random ALU, load and store over x0..x7 and the first 64 words
        for (int i = 0; i < 200; i++) begin
            kind = $urandom_range(4, 0);
            case (kind)
                0: prog.push_back(addi($urandom_range(7, 1), $urandom_range(7, 0),
                                       $urandom_range(4095, 0)));
                1: prog.push_back(enc_r($urandom_range(1, 0) * 32, $urandom_range(7, 0),
                                        $urandom_range(7, 0), 0, $urandom_range(7, 1)));
                2: begin
                    // SLT, XOR, OR or AND
                    funct3 = $urandom_range(7, 4);
                    if (funct3 == 5) begin
                        funct3 = 2;
                    end
                    prog.push_back(enc_r(0, $urandom_range(7, 0), $urandom_range(7, 0),
                                         funct3, $urandom_range(7, 1)));
                end
                3: prog.push_back(enc_i($urandom_range(63, 0) * 4, 0, 2, $urandom_range(7, 0),
                                        OPC_LOAD));
                default: prog.push_back(enc_s($urandom_range(63, 0) * 4,
                                              $urandom_range(7, 0), 0));
            endcase
        end
        prog.push_back(SELF_LOOP);
        run_program("random");

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
